/* rename_core.f */
+incdir+src
src/uop_pkg.sv
src/rename_pkg.sv
src/free_list.sv
src/map_table.sv
src/register_rename.sv
src/rename_stage.sv
verification/rename_checker.sv
verification/tb_rename_stage.sv

/* run_sim.sh */
#!/bin/sh
# builds the rename stage testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f rename_core.f \
    --top-module tb_rename_stage

./obj_dir/Vtb_rename_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

/* src/free_list.sv */
`include "rename_consts.svh"

module free_list import uop_pkg::*, rename_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          recover,
    input  logic [1:0]    alloc_req,
    output preg_t         alloc0_preg,
    output preg_t         alloc1_preg,
    output logic          can_alloc,
    input  commit_t [1:0] commit
);

    typedef logic [`RENAME_PREG_W:0] ptr_t;   // top bit tells full from empty

    preg_t      fifo [`RENAME_PREGS];
    ptr_t       spec_head;     // next register handed out
    ptr_t       commit_head;   // first register not yet retired
    ptr_t       tail;          // next slot for a freed register
    ptr_t       head_p1;
    ptr_t       tail_slot1;
    ptr_t       free_cnt;
    ptr_t       alloc_cnt;
    ptr_t       retire_cnt;
    logic [1:0] frees;
    fl_state_e  fl_mode;

    assign fl_mode = recover ? fl_recover : fl_run;

    // commits in the recover cycle are dropped
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            frees[i] = commit[i].valid && commit[i].dst_we && (fl_mode == fl_run);
        end
    end

    assign alloc_cnt  = ptr_t'(alloc_req[0]) + ptr_t'(alloc_req[1]);
    assign retire_cnt = ptr_t'(frees[0]) + ptr_t'(frees[1]);
    assign free_cnt   = tail - spec_head;
    assign can_alloc  = free_cnt >= ptr_t'(2);

    assign head_p1    = spec_head + ptr_t'(1);
    assign tail_slot1 = tail + ptr_t'(frees[0]);   // slot 0 is freed first

    assign alloc0_preg = fifo[spec_head[`RENAME_PREG_W-1:0]];
    // slot 1 takes the head when slot 0 does not allocate
    assign alloc1_preg = alloc_req[0] ? fifo[head_p1[`RENAME_PREG_W-1:0]] : alloc0_preg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= ptr_t'(`RENAME_FREE_INIT);
        end else begin
            case (fl_mode)
                fl_recover: begin
                    spec_head <= commit_head;   // drop every speculative allocation
                end
                default: begin
                    spec_head   <= spec_head + alloc_cnt;
                    commit_head <= commit_head + retire_cnt;
                    tail        <= tail + retire_cnt;
                end
            endcase
        end
    end

    // registers 32 to 63 sit in entries 0 to 31 after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RENAME_PREGS; i++) begin
                fifo[i] <= preg_t'(i + `RENAME_FREE_INIT);
            end
        end else begin
            if (frees[0]) begin
                fifo[tail[`RENAME_PREG_W-1:0]] <= commit[0].dst_stale;
            end
            if (frees[1]) begin
                fifo[tail_slot1[`RENAME_PREG_W-1:0]] <= commit[1].dst_stale;
            end
        end
    end

    free_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        free_cnt <= ptr_t'(`RENAME_PREGS));

    // accept in the top must never ask for more than is free
    alloc_covered: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_cnt <= free_cnt);

endmodule

/* src/map_table.sv */
`include "rename_consts.svh"

module map_table import uop_pkg::*, rename_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              recover,
    input  logic              accept,
    input  rename_req_t [1:0] req,
    input  preg_t [1:0]       new_preg,
    output rename_rsp_t [1:0] rsp,
    input  commit_t [1:0]     commit
);

    preg_t      spec_map [`RENAME_LREGS];
    preg_t      commit_map [`RENAME_LREGS];
    logic [1:0] commit_wr;
    logic       byp_src0;
    logic       byp_src1;
    logic       byp_dst;

    // slot 0 reads the speculative map as it stands
    assign rsp[0].src0_preg = spec_map[req[0].src0_lreg];
    assign rsp[0].src1_preg = spec_map[req[0].src1_lreg];
    assign rsp[0].dst_stale = spec_map[req[0].dst_lreg];

    // slot 1 must see the mapping slot 0 creates in the same bundle
    assign byp_src0 = req[0].wen && (req[0].dst_lreg == req[1].src0_lreg);
    assign byp_src1 = req[0].wen && (req[0].dst_lreg == req[1].src1_lreg);
    assign byp_dst  = req[0].wen && (req[0].dst_lreg == req[1].dst_lreg);

    assign rsp[1].src0_preg = byp_src0 ? new_preg[0] : spec_map[req[1].src0_lreg];
    assign rsp[1].src1_preg = byp_src1 ? new_preg[0] : spec_map[req[1].src1_lreg];
    assign rsp[1].dst_stale = byp_dst  ? new_preg[0] : spec_map[req[1].dst_lreg];

    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            commit_wr[i] = commit[i].valid && commit[i].dst_we && !recover;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RENAME_LREGS; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (recover) begin
            for (int i = 0; i < `RENAME_LREGS; i++) begin
                spec_map[i] <= commit_map[i];
            end
        end else if (accept) begin
            if (req[0].wen) begin
                spec_map[req[0].dst_lreg] <= new_preg[0];
            end
            if (req[1].wen) begin
                spec_map[req[1].dst_lreg] <= new_preg[1];   // younger write wins
            end
        end
    end

    // committed state, the target of every recover
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RENAME_LREGS; i++) begin
                commit_map[i] <= preg_t'(i);
            end
        end else begin
            if (commit_wr[0]) begin
                commit_map[commit[0].dst_lreg] <= commit[0].dst_preg;
            end
            if (commit_wr[1]) begin
                commit_map[commit[1].dst_lreg] <= commit[1].dst_preg;
            end
        end
    end

    // the top blocks acceptance during a recover pulse
    no_accept_on_recover: assert property (@(posedge clk) disable iff (!rst_n)
        !(accept && recover));

    // the free list hands two writers two different registers
    distinct_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && req[0].wen && req[1].wen) |-> (new_preg[0] != new_preg[1]));

endmodule

/* src/register_rename.sv */
module register_rename import uop_pkg::*, rename_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          accept,
    input  logic          recover,
    input  uop_bundle_t   in_bundle,
    input  commit_t [1:0] commit,
    output uop_bundle_t   renamed,
    output logic          can_alloc
);

    uop_t [1:0]        uop_in;
    uop_t [1:0]        uop_out;
    rename_req_t [1:0] req;
    rename_rsp_t [1:0] rsp;
    preg_t [1:0]       new_preg;
    logic [1:0]        alloc_req;

    assign uop_in = {in_bundle.slot1, in_bundle.slot0};

    // only valid writers touch the map or the free list
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            req[s].src0_lreg = uop_in[s].src0_lreg;
            req[s].src1_lreg = uop_in[s].src1_lreg;
            req[s].dst_lreg  = uop_in[s].dst_lreg;
            req[s].wen       = uop_in[s].valid && uop_in[s].dst_we;
            alloc_req[s]     = accept && req[s].wen;
        end
    end

    free_list i_free_list (
        .clk         (clk),
        .rst_n       (rst_n),
        .recover     (recover),
        .alloc_req   (alloc_req),
        .alloc0_preg (new_preg[0]),
        .alloc1_preg (new_preg[1]),
        .can_alloc   (can_alloc),
        .commit      (commit)
    );

    map_table i_map_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .recover  (recover),
        .accept   (accept),
        .req      (req),
        .new_preg (new_preg),
        .rsp      (rsp),
        .commit   (commit)
    );

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            uop_out[s]           = uop_in[s];
            uop_out[s].src0_preg = rsp[s].src0_preg;
            uop_out[s].src1_preg = rsp[s].src1_preg;
            uop_out[s].dst_stale = rsp[s].dst_stale;
            uop_out[s].dst_preg  = uop_in[s].dst_we ? new_preg[s] : '0;   // no write, no register
        end
    end

    assign renamed.slot0 = uop_out[0];
    assign renamed.slot1 = uop_out[1];

endmodule

/* src/rename_consts.svh */
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// architectural and physical register files
`define RENAME_LREGS      32
`define RENAME_PREGS      64
`define RENAME_LREG_W     5
`define RENAME_PREG_W     6

// physical registers not claimed by the identity map at reset
`define RENAME_FREE_INIT  32

// micro-ops renamed per cycle
`define RENAME_WIDTH      2

// one credit per dispatch queue slot
`define RENAME_CREDITS    4
`define RENAME_CREDIT_W   3

`endif

/* src/rename_pkg.sv */
package rename_pkg;

    import uop_pkg::*;

    // lookup and update for one slot
    typedef struct packed {
        lreg_t src0_lreg;
        lreg_t src1_lreg;
        lreg_t dst_lreg;
        logic  wen;
    } rename_req_t;

    typedef struct packed {
        preg_t src0_preg;
        preg_t src1_preg;
        preg_t dst_stale;
    } rename_rsp_t;

    // retiring micro-op handed back to rename
    typedef struct packed {
        logic  valid;
        logic  dst_we;
        lreg_t dst_lreg;
        preg_t dst_preg;
        preg_t dst_stale;   // goes back onto the free list
    } commit_t;

    // recover rewinds the free list for one cycle
    typedef enum logic {
        fl_run,
        fl_recover
    } fl_state_e;

endpackage

/* src/rename_stage.sv */
`include "rename_consts.svh"

module rename_stage import uop_pkg::*, rename_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  uop_bundle_t   in_bundle,
    output logic          in_ready,
    input  commit_t [1:0] commit,
    input  logic          recover,
    output uop_bundle_t   out_bundle,
    output logic          out_valid,
    input  logic          credit_return
);

    typedef logic [`RENAME_CREDIT_W-1:0] credit_t;

    credit_t     credit_cnt;
    logic        credit_ok;
    logic        can_alloc;
    logic        accept;
    uop_bundle_t renamed;

    // a bundle in the output register still has to spend its credit
    assign credit_ok = credit_cnt > credit_t'(out_valid);
    assign in_ready  = can_alloc && credit_ok && !recover;
    assign accept    = in_ready && (in_bundle.slot0.valid || in_bundle.slot1.valid);

    register_rename i_register_rename (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .recover   (recover),
        .in_bundle (in_bundle),
        .commit    (commit),
        .renamed   (renamed),
        .can_alloc (can_alloc)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            credit_cnt <= credit_t'(`RENAME_CREDITS);
        end else begin
            out_valid <= accept;
            case ({out_valid, credit_return})
                2'b10:   credit_cnt <= credit_cnt - credit_t'(1);
                2'b01:   credit_cnt <= credit_cnt + credit_t'(1);
                default: credit_cnt <= credit_cnt;   // spend and return cancel out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) out_bundle <= renamed;
    end

    credit_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= credit_t'(`RENAME_CREDITS));

    credit_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (credit_cnt != '0));

endmodule

/* src/uop_pkg.sv */
`include "rename_consts.svh"

package uop_pkg;

    typedef logic [`RENAME_LREG_W-1:0] lreg_t;   // logical register index
    typedef logic [`RENAME_PREG_W-1:0] preg_t;   // physical register index

    // one micro-op as seen on both sides of rename
    typedef struct packed {
        logic       valid;
        logic       dst_we;
        lreg_t      src0_lreg;
        lreg_t      src1_lreg;
        lreg_t      dst_lreg;
        preg_t      src0_preg;
        preg_t      src1_preg;
        preg_t      dst_preg;
        preg_t      dst_stale;   // mapping replaced by dst_preg
        logic [7:0] tag;         // opaque, passed through unchanged
    } uop_t;

    // slot 0 is older than slot 1
    typedef struct packed {
        uop_t slot1;
        uop_t slot0;
    } uop_bundle_t;

endpackage

/* verification/rename_checker.sv */
module rename_checker import uop_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        out_valid,
    input  uop_bundle_t out_bundle,
    input  logic        exp_push,
    input  uop_bundle_t exp_bundle,
    input  logic        step_end,
    input  int          step_idx,
    input  int          tb_errors,
    output int          errors,
    output int          checks,
    output int          pending
);

    timeunit 1ns;
    timeprecision 100ps;

    uop_bundle_t exp_q[$];
    uop_bundle_t want;
    int          step_base;
    logic        due;   // a bundle was accepted on the last rising edge

    initial begin
        errors    = 0;
        checks    = 0;
        pending   = 0;
        step_base = 0;
        due       = 1'b0;
    end

    task automatic compare_field(int slot, string name, logic [7:0] got, logic [7:0] exp_v);
        if (got !== exp_v) begin
            $display("[FAIL] slot%0d.%s got 0x%02h expected 0x%02h", slot, name, got, exp_v);
            errors++;
        end
    endtask

    task automatic compare_uop(int slot, uop_t got, uop_t exp_u);
        compare_field(slot, "valid", 8'(got.valid), 8'(exp_u.valid));
        compare_field(slot, "dst_we", 8'(got.dst_we), 8'(exp_u.dst_we));
        compare_field(slot, "src0_lreg", 8'(got.src0_lreg), 8'(exp_u.src0_lreg));
        compare_field(slot, "src1_lreg", 8'(got.src1_lreg), 8'(exp_u.src1_lreg));
        compare_field(slot, "dst_lreg", 8'(got.dst_lreg), 8'(exp_u.dst_lreg));
        compare_field(slot, "src0_preg", 8'(got.src0_preg), 8'(exp_u.src0_preg));
        compare_field(slot, "src1_preg", 8'(got.src1_preg), 8'(exp_u.src1_preg));
        compare_field(slot, "dst_preg", 8'(got.dst_preg), 8'(exp_u.dst_preg));
        compare_field(slot, "dst_stale", 8'(got.dst_stale), 8'(exp_u.dst_stale));
        compare_field(slot, "tag", got.tag, exp_u.tag);
    endtask

    // expected bundle is queued on the accepting edge
    always @(posedge clk) begin
        due = rst_n && exp_push;
        if (due) exp_q.push_back(exp_bundle);
    end

    always @(negedge clk) begin
        if (rst_n && (out_valid || due)) begin
            if (!due) begin
                $display("unexpected out_valid while no renamed bundle was expected");
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (!out_valid) begin
                    $display("out_valid missing one cycle after an accepted bundle");
                    errors++;
                end else begin
                    compare_uop(0, out_bundle.slot0, want.slot0);
                    compare_uop(1, out_bundle.slot1, want.slot1);
                    checks++;
                end
            end
        end
        if (step_end) begin
            if (errors + tb_errors == step_base) $display("step %0d: ok", step_idx);
            else $display("step %0d: %0d errors", step_idx, errors + tb_errors - step_base);
            step_base = errors + tb_errors;
        end
        pending = exp_q.size();
    end

endmodule

/* verification/tb_rename_stage.sv */
`include "rename_consts.svh"

module tb_rename_stage import uop_pkg::*, rename_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_BUNDLE = 0;   // wait for in_ready, then accept
    localparam int K_BLOCK = 1;    // in_ready must stay low
    localparam int K_IDLE = 2;     // commits and credit returns only
    localparam int K_RECOVER = 3;

    typedef struct {
        int   kind;
        uop_t s0;
        uop_t s1;
        int   commit_n;
        int   ret;
        bit   hold;      // keep the credit of this bundle
    } step_t;

    logic          clk = 1'b0;
    logic          rst_n;
    uop_bundle_t   in_bundle;
    logic          in_ready;
    commit_t [1:0] commit;
    logic          recover;
    uop_bundle_t   out_bundle;
    logic          out_valid;
    logic          credit_return;
    logic          exp_push;
    uop_bundle_t   exp_bundle;
    logic          step_end;
    int            step_idx;
    int            tb_errors;
    int            errors;
    int            checks;
    int            pending;
    logic          timed_out;

    // reference rename state
    preg_t       spec_map [`RENAME_LREGS];
    preg_t       commit_map [`RENAME_LREGS];
    preg_t       fq [`RENAME_PREGS];
    int          spec_head;
    int          commit_head;
    int          tail;
    uop_t        inflight[$];
    step_t       steps[$];
    logic [31:0] rng = 32'd1886;

    always #5 clk = ~clk;

    rename_stage i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_bundle     (in_bundle),
        .in_ready      (in_ready),
        .commit        (commit),
        .recover       (recover),
        .out_bundle    (out_bundle),
        .out_valid     (out_valid),
        .credit_return (credit_return)
    );

    rename_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .exp_push   (exp_push),
        .exp_bundle (exp_bundle),
        .step_end   (step_end),
        .step_idx   (step_idx),
        .tb_errors  (tb_errors),
        .errors     (errors),
        .checks     (checks),
        .pending    (pending)
    );

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic uop_t make_uop(bit v, bit we, int s0, int s1, int d);
        uop_t u;
        u = '0;
        u.valid     = v;
        u.dst_we    = we;
        u.src0_lreg = lreg_t'(s0);
        u.src1_lreg = lreg_t'(s1);
        u.dst_lreg  = lreg_t'(d);
        u.tag       = 8'(xorshift());
        return u;
    endfunction

    function automatic void add_step(int kind, uop_t s0, uop_t s1, int cn, int ret, bit hold);
        step_t st;
        st.kind     = kind;
        st.s0       = s0;
        st.s1       = s1;
        st.commit_n = cn;
        st.ret      = ret;
        st.hold     = hold;
        steps.push_back(st);
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < `RENAME_LREGS; i++) begin
            spec_map[i]   = preg_t'(i);
            commit_map[i] = preg_t'(i);
        end
        for (int i = 0; i < `RENAME_PREGS; i++) begin
            fq[i] = (i < `RENAME_FREE_INIT) ? preg_t'(i + `RENAME_FREE_INIT) : '0;
        end
        spec_head   = 0;
        commit_head = 0;
        tail        = `RENAME_FREE_INIT;
    endfunction

    // slots renamed in order, so slot 1 sees slot 0's new mapping
    function automatic uop_bundle_t rename_model(uop_t s0, uop_t s1);
        uop_t        u [2];
        uop_bundle_t b;
        u[0] = s0;
        u[1] = s1;
        for (int s = 0; s < 2; s++) begin
            u[s].src0_preg = spec_map[u[s].src0_lreg];
            u[s].src1_preg = spec_map[u[s].src1_lreg];
            u[s].dst_stale = spec_map[u[s].dst_lreg];
            u[s].dst_preg  = '0;
            if (u[s].valid && u[s].dst_we) begin
                u[s].dst_preg = fq[6'(spec_head)];
                spec_head++;
                spec_map[u[s].dst_lreg] = u[s].dst_preg;
                inflight.push_back(u[s]);
            end
        end
        b.slot0 = u[0];
        b.slot1 = u[1];
        return b;
    endfunction

    function automatic commit_t retire_model();
        uop_t    u;
        commit_t c;
        u = inflight.pop_front();
        c.valid     = 1'b1;
        c.dst_we    = 1'b1;
        c.dst_lreg  = u.dst_lreg;
        c.dst_preg  = u.dst_preg;
        c.dst_stale = u.dst_stale;
        commit_map[u.dst_lreg] = u.dst_preg;
        fq[6'(tail)] = u.dst_stale;
        tail++;
        commit_head++;
        return c;
    endfunction

    function automatic void build_table();
        uop_t none;
        none = make_uop(0, 0, 0, 0, 0);
        // fresh registers in order, identity sources
        add_step(K_BUNDLE, make_uop(1, 1, 1, 2, 5), make_uop(1, 1, 3, 4, 6), 0, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 1, 5, 6, 7), make_uop(1, 1, 7, 0, 8), 0, 0, 0);
        // bypass of slot 0's destination, slot without write
        add_step(K_BUNDLE, make_uop(1, 1, 5, 6, 5), make_uop(1, 1, 5, 7, 5), 0, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 0, 5, 9, 9), make_uop(1, 1, 9, 5, 9), 0, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 1, 9, 5, 10), none, 0, 0, 0);
        // credits run out
        for (int i = 0; i < `RENAME_CREDITS; i++) begin
            add_step(K_BUNDLE, make_uop(1, 0, i, i + 1, 2), make_uop(1, 0, 3, i, 4), 0, 0, 1);
        end
        add_step(K_BLOCK, make_uop(1, 0, 1, 2, 3), none, 0, 0, 0);
        add_step(K_IDLE, none, none, 0, 1, 0);
        add_step(K_BUNDLE, make_uop(1, 0, 8, 9, 3), none, 0, 0, 1);
        add_step(K_BLOCK, make_uop(1, 0, 1, 2, 3), none, 0, 0, 0);
        add_step(K_IDLE, none, none, 0, `RENAME_CREDITS, 0);
        // drain the free list down to one register
        for (int i = 0; i < 11; i++) begin
            add_step(K_BUNDLE, make_uop(1, 1, i, i + 3, 11 + i % 10),
                     make_uop(1, 1, i + 1, 11 + i % 10, 12 + i % 9), 0, 0, 0);
        end
        add_step(K_BUNDLE, make_uop(1, 1, 4, 12, 13), none, 0, 0, 0);
        add_step(K_BLOCK, make_uop(1, 1, 1, 2, 3), none, 0, 0, 0);
        add_step(K_IDLE, none, none, 8, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 1, 1, 2, 3), make_uop(1, 1, 3, 4, 4), 0, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 1, 5, 6, 14), make_uop(1, 1, 14, 7, 15), 0, 0, 0);
        // speculative work thrown away by recover
        add_step(K_BUNDLE, make_uop(1, 1, 5, 6, 20), make_uop(1, 1, 20, 7, 21), 0, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 1, 20, 21, 5), none, 0, 0, 0);
        add_step(K_RECOVER, none, none, 0, 0, 0);
        add_step(K_BUNDLE, make_uop(1, 1, 20, 21, 22), make_uop(1, 1, 5, 22, 23), 0, 0, 0);
    endfunction

    task automatic report_timeout(string what);
        $display("timeout after 50 cycles waiting for %s", what);
        tb_errors++;
        timed_out = 1'b1;
    endtask

    task automatic run_bundle(step_t st);
        int n;
        n = 0;
        in_bundle.slot0 = st.s0;
        in_bundle.slot1 = st.s1;
        @(negedge clk);
        while (!in_ready && !timed_out) begin
            n++;
            if (n > 50) report_timeout("in_ready");
            else @(negedge clk);
        end
        if (!timed_out) begin
            exp_bundle = rename_model(st.s0, st.s1);
            exp_push   = 1'b1;
            @(posedge clk);
            #1;
            in_bundle     = '0;
            exp_push      = 1'b0;
            credit_return = !st.hold;
            @(posedge clk);
            #1;
            credit_return = 1'b0;
        end
    endtask

    task automatic run_block(step_t st);
        in_bundle.slot0 = st.s0;
        in_bundle.slot1 = st.s1;
        repeat (3) begin
            @(negedge clk);
            if (in_ready) begin
                $display("in_ready is high although the stage should be blocked");
                tb_errors++;
            end
        end
        @(posedge clk);
        #1;
        in_bundle = '0;
    endtask

    task automatic run_idle(step_t st);
        int left;
        int rets;
        left = st.commit_n;
        rets = st.ret;
        while (left > 0 || rets > 0) begin
            for (int k = 0; k < 2; k++) begin
                commit[k] = '0;
                if (left > 0) begin
                    commit[k] = retire_model();
                    left--;
                end
            end
            credit_return = (rets > 0);
            if (rets > 0) rets--;
            @(posedge clk);
            #1;
            commit        = '0;
            credit_return = 1'b0;
        end
    endtask

    initial begin
        int n;
        rst_n         = 1'b0;
        in_bundle     = '0;
        commit        = '0;
        recover       = 1'b0;
        credit_return = 1'b0;
        exp_push      = 1'b0;
        exp_bundle    = '0;
        step_end      = 1'b0;
        step_idx      = 0;
        tb_errors     = 0;
        timed_out     = 1'b0;
        build_table();
        reset_model();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            step_idx = i;
            case (steps[i].kind)
                K_BUNDLE: run_bundle(steps[i]);
                K_BLOCK:  run_block(steps[i]);
                K_IDLE:   run_idle(steps[i]);
                default: begin
                    recover = 1'b1;
                    spec_map  = commit_map;   // rewind to the committed state
                    spec_head = commit_head;
                    inflight.delete();
                    @(posedge clk);
                    #1;
                    recover = 1'b0;
                end
            endcase
            step_end = 1'b1;
            @(posedge clk);
            #1;
            step_end = 1'b0;
        end
        n = 0;
        while (pending != 0 && !timed_out) begin
            n++;
            if (n > 50) report_timeout("out_valid of the last bundles");
            else @(posedge clk);
        end
        $display("%0d steps, %0d bundles checked, %0d errors",
                 steps.size(), checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
